// File: ldpc_vnode.f
+incdir+hw
hw/ldpc_vnode_pkg.sv
hw/ldpc_vnode_ctrl.sv
hw/ldpc_vnode_engine.sv
hw/ldpc_vnode_writeback.sv
hw/ldpc_vnode_err_count.sv
hw/ldpc_vnode.sv
verification/tb_ldpc_vnode.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the ldpc variable-node testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
  --top-module tb_ldpc_vnode \
  -f ldpc_vnode.f \
  -o sim_ldpc_vnode \
  && ./obj_dir/sim_ldpc_vnode > sim.log 2>&1 \
  || echo "build or simulation returned an error status"

touch sim.log
cat sim.log

grep -qx "sim passed" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// File: verification/tb_ldpc_vnode.sv
// ldpc variable-node stage testbench with lfsr stimulus, reference queues and negedge assertions

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module tb_ldpc_vnode;

  localparam int L      = `LDPC_LLR_BY_CYCLE;
  localparam int N      = `LDPC_NODE_BY_CYCLE;
  localparam int SHIFT  = `LDPC_NODE_W - `LDPC_LLR_W;
  localparam int NODE_FW  = `LDPC_C * `LDPC_LANES * `LDPC_NODE_W;  // flat message word
  localparam int STATE_FW = `LDPC_C * `LDPC_LANES * 2;
  localparam int UP_WORDS   = 6;
  localparam int DEC_WORDS  = 8;
  localparam int DEC_FRAMES = 3;
  localparam int GAP_MAX    = 6;  // 3 fixed + 2 random bits
  localparam int STIM_CYCLES = 8 + 2 * UP_WORDS + DEC_FRAMES * (2 * DEC_WORDS + GAP_MAX) + 8;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 20;

  typedef struct packed {
    int                      due;
    logic [`LDPC_ADDR_W-1:0] addr;
    logic [NODE_FW-1:0]      node;
    logic [STATE_FW-1:0]     state;
  } wr_item_t;

  typedef struct packed {
    int                     due;
    logic                   sop;
    logic                   eop;
    logic [`LDPC_LANES-1:0] dat;   // column n at [n*L +: L]
    logic [`LDPC_ERR_W-1:0] err;
  } bit_item_t;

  typedef struct packed {
    int   due;
    logic lvl;
  } busy_item_t;

  logic iclk = 1'b0;
  logic ireset;
  logic isop, ival, ieop, iusop, iuval;
  ldpc_vnode_pkg::llr_t        illr    [L][N];
  ldpc_vnode_pkg::node_t       icnode  [`LDPC_C][L][N];
  ldpc_vnode_pkg::node_state_t icstate [`LDPC_C][L][N];
  ldpc_vnode_pkg::llr_t        iullr   [L][N];
  logic                        oval;
  ldpc_vnode_pkg::mem_addr_t   oaddr;
  ldpc_vnode_pkg::node_t       ovnode  [`LDPC_C][L][N];
  ldpc_vnode_pkg::node_state_t ovstate [`LDPC_C][L][N];
  logic                        obitsop, obitval, obiteop, obusy;
  logic [L-1:0]                obitdat [N];
  logic [`LDPC_ERR_W-1:0]      obiterr;

  logic [NODE_FW-1:0]      ovnode_flat;
  logic [STATE_FW-1:0]     ovstate_flat;
  logic [`LDPC_LANES-1:0]  bitdat_flat;

  int                      cyc = 0;          // posedge count used by drives and checks
  logic [31:0]             lfsr = 32'hfd83;
  logic [`LDPC_ADDR_W-1:0] model_addr = '0;
  wr_item_t                wr_q   [$];
  bit_item_t               bit_q  [$];
  busy_item_t              busy_q [$];

  // expectation for the current cycle settled at posedge
  logic                    exp_oval, exp_bitval, exp_bitsop, exp_biteop, exp_busy;
  logic [`LDPC_ADDR_W-1:0] exp_addr;
  logic [NODE_FW-1:0]      exp_node;
  logic [STATE_FW-1:0]     exp_state;
  logic [`LDPC_LANES-1:0]  exp_bitdat;
  logic [`LDPC_ERR_W-1:0]  exp_biterr;

  ldpc_vnode ldpc_vnode_inst (
    .iclk (iclk), .ireset (ireset),
    .isop (isop), .ival (ival), .ieop (ieop),
    .illr (illr), .icnode (icnode), .icstate (icstate),
    .iusop (iusop), .iuval (iuval), .iullr (iullr),
    .oval (oval), .oaddr (oaddr), .ovnode (ovnode), .ovstate (ovstate),
    .obitsop (obitsop), .obitval (obitval), .obiteop (obiteop),
    .obitdat (obitdat), .obiterr (obiterr), .obusy (obusy)
  );

  always #5 iclk = ~iclk;  // 10 ns period

  // ------------------------------------------------------------
  // reference helpers
  // ------------------------------------------------------------
  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int clip_to_node(input int v);
    int hi;
    int lo;
    hi = (1 << (`LDPC_NODE_W - 1)) - 1;
    lo = -(1 << (`LDPC_NODE_W - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  // write address that restarts on sop
  function automatic logic [`LDPC_ADDR_W-1:0] step_write_address(input logic sop);
    if (sop) model_addr = '0;
    else model_addr = model_addr + `LDPC_ADDR_W'(1);
    return model_addr;
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] gotv);
    $display("FAIL %0t ns %s expected %0h got %0h", $time, name, expv, gotv);
    abort_run();
  endtask

  // ------------------------------------------------------------
  // drivers on the falling edge
  // ------------------------------------------------------------
  task automatic drive_idle();
    @(negedge iclk);
    isop  = 1'b0;
    ival  = 1'b0;
    ieop  = 1'b0;
    iusop = 1'b0;
    iuval = 1'b0;
  endtask

  task automatic drive_upload_word(input logic sop);
    wr_item_t w;
    int       up;
    int       idx;
    @(negedge iclk);
    w = '0;
    for (int l = 0; l < L; l++) begin
      for (int n = 0; n < N; n++) begin
        iullr[l][n] = ldpc_vnode_pkg::llr_t'(rand_bits(`LDPC_LLR_W));
        up = int'(iullr[l][n]) * (1 << SHIFT);  // llr at the top of the word
        for (int c = 0; c < `LDPC_C; c++) begin
          idx = (c * L + l) * N + n;
          w.node[idx*`LDPC_NODE_W +: `LDPC_NODE_W] = up[`LDPC_NODE_W-1:0];
          w.state[idx*2 +: 2] = 2'b01;             // sign 0 and zero 1
        end
      end
    end
    isop  = 1'b0;
    ival  = 1'b0;
    ieop  = 1'b0;
    iusop = sop;
    iuval = 1'b1;
    w.due  = cyc + 1;
    w.addr = step_write_address(sop);
    wr_q.push_back(w);
  endtask

  task automatic drive_decode_word(input logic sop, input logic eop);
    wr_item_t  w;
    bit_item_t b;
    int        llr_v, tot, ext, idx, errs;
    int        msg [`LDPC_C];
    logic      hard;
    @(negedge iclk);
    w = '0;
    b = '0;
    errs = 0;
    for (int l = 0; l < L; l++) begin
      for (int n = 0; n < N; n++) begin
        illr[l][n] = ldpc_vnode_pkg::llr_t'(rand_bits(`LDPC_LLR_W));
        llr_v = int'(illr[l][n]);
        tot   = llr_v * (1 << SHIFT);
        for (int c = 0; c < `LDPC_C; c++) begin
          icnode[c][l][n]  = ldpc_vnode_pkg::node_t'(rand_bits(`LDPC_NODE_W));
          icstate[c][l][n] = ldpc_vnode_pkg::node_state_t'(rand_bits(2));  // unused by dut
          msg[c] = int'(icnode[c][l][n]);
          tot    = tot + msg[c];
        end
        for (int c = 0; c < `LDPC_C; c++) begin
          ext = clip_to_node(tot - msg[c]);  // extrinsic leaves its own edge out
          idx = (c * L + l) * N + n;
          w.node[idx*`LDPC_NODE_W +: `LDPC_NODE_W] = ext[`LDPC_NODE_W-1:0];
          w.state[idx*2 +: 2] = {ext < 0, ext == 0};
        end
        hard = (tot < 0);
        b.dat[n*L + l] = hard;
        if (hard != (llr_v < 0)) errs++;
      end
    end
    isop  = sop;
    ival  = 1'b1;
    ieop  = eop;
    iusop = 1'b0;
    iuval = 1'b0;
    w.due  = cyc + 3;
    w.addr = step_write_address(sop);
    wr_q.push_back(w);
    b.due = cyc + 4;
    b.sop = sop;
    b.eop = eop;
    b.err = `LDPC_ERR_W'(errs);
    bit_q.push_back(b);
    if (sop) busy_q.push_back('{due: cyc + 1, lvl: 1'b1});
    if (eop) busy_q.push_back('{due: cyc + 4, lvl: 1'b0});  // after the eop write
  endtask

  // ------------------------------------------------------------
  // expectations for the coming cycle
  // ------------------------------------------------------------
  always @(posedge iclk) begin
    cyc <= cyc + 1;
    exp_oval   <= 1'b0;
    exp_bitval <= 1'b0;
    exp_bitsop <= 1'b0;
    exp_biteop <= 1'b0;
    if (ireset) begin
      exp_busy <= 1'b0;
    end else begin
      if (wr_q.size() > 0 && wr_q[0].due == cyc + 1) begin
        exp_oval  <= 1'b1;
        exp_addr  <= wr_q[0].addr;
        exp_node  <= wr_q[0].node;
        exp_state <= wr_q[0].state;
        void'(wr_q.pop_front());
      end
      if (bit_q.size() > 0 && bit_q[0].due == cyc + 1) begin
        exp_bitval <= 1'b1;
        exp_bitsop <= bit_q[0].sop;
        exp_biteop <= bit_q[0].eop;
        exp_bitdat <= bit_q[0].dat;
        exp_biterr <= bit_q[0].err;
        void'(bit_q.pop_front());
      end
      if (busy_q.size() > 0 && busy_q[0].due == cyc + 1) begin
        exp_busy <= busy_q[0].lvl;
        void'(busy_q.pop_front());
      end
    end
  end

  // dut arrays flattened in the same order as the model
  always_comb begin
    for (int c = 0; c < `LDPC_C; c++) begin
      for (int l = 0; l < L; l++) begin
        for (int n = 0; n < N; n++) begin
          ovnode_flat[((c*L + l)*N + n)*`LDPC_NODE_W +: `LDPC_NODE_W] = ovnode[c][l][n];
          ovstate_flat[((c*L + l)*N + n)*2 +: 2] = ovstate[c][l][n];
        end
      end
    end
    for (int n = 0; n < N; n++) begin
      for (int l = 0; l < L; l++) begin
        bitdat_flat[n*L + l] = obitdat[n][l];
      end
    end
  end

  // ------------------------------------------------------------
  // checks sampled mid cycle where dut outputs are settled
  // ------------------------------------------------------------
  a_oval : assert property (@(negedge iclk) disable iff (ireset) oval == exp_oval)
    else report_mismatch("oval", 64'(exp_oval), 64'(oval));
  a_oaddr : assert property (@(negedge iclk) disable iff (ireset)
    !exp_oval || oaddr == exp_addr)
    else report_mismatch("oaddr", 64'(exp_addr), 64'(oaddr));
  a_ovnode : assert property (@(negedge iclk) disable iff (ireset)
    !exp_oval || ovnode_flat == exp_node)
    else report_mismatch("ovnode", 64'(exp_node), 64'(ovnode_flat));
  a_ovstate : assert property (@(negedge iclk) disable iff (ireset)
    !exp_oval || ovstate_flat == exp_state)
    else report_mismatch("ovstate", 64'(exp_state), 64'(ovstate_flat));
  a_obitval : assert property (@(negedge iclk) disable iff (ireset) obitval == exp_bitval)
    else report_mismatch("obitval", 64'(exp_bitval), 64'(obitval));
  a_obitsop : assert property (@(negedge iclk) disable iff (ireset) obitsop == exp_bitsop)
    else report_mismatch("obitsop", 64'(exp_bitsop), 64'(obitsop));
  a_obiteop : assert property (@(negedge iclk) disable iff (ireset) obiteop == exp_biteop)
    else report_mismatch("obiteop", 64'(exp_biteop), 64'(obiteop));
  a_obitdat : assert property (@(negedge iclk) disable iff (ireset)
    !exp_bitval || bitdat_flat == exp_bitdat)
    else report_mismatch("obitdat", 64'(exp_bitdat), 64'(bitdat_flat));
  a_obiterr : assert property (@(negedge iclk) disable iff (ireset)
    !exp_bitval || obiterr == exp_biterr)
    else report_mismatch("obiterr", 64'(exp_biterr), 64'(obiterr));
  a_obusy : assert property (@(negedge iclk) disable iff (ireset) obusy == exp_busy)
    else report_mismatch("obusy", 64'(exp_busy), 64'(obusy));
  a_reset_quiet : assert property (@(negedge iclk)
    !ireset || !(oval || obitval || obitsop || obiteop || obusy))
    else begin
      $display("a strobe or busy output is high while reset is held, at %0t ns", $time);
      abort_run();
    end

  // watchdog
  always @(posedge iclk) begin
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    ireset = 1'b1;
    isop   = 1'b0;
    ival   = 1'b0;
    ieop   = 1'b0;
    iusop  = 1'b0;
    iuval  = 1'b0;
    for (int l = 0; l < L; l++) begin
      for (int n = 0; n < N; n++) begin
        illr[l][n]  = '0;
        iullr[l][n] = '0;
        for (int c = 0; c < `LDPC_C; c++) begin
          icnode[c][l][n]  = '0;
          icstate[c][l][n] = '0;
        end
      end
    end
    repeat (2) @(negedge iclk);
    ireset = 1'b0;
    repeat (2) drive_idle();

    for (int i = 0; i < UP_WORDS; i++) drive_upload_word(i == 0);
    repeat (3) drive_idle();

    for (int f = 0; f < DEC_FRAMES; f++) begin
      for (int w = 0; w < DEC_WORDS; w++) begin
        drive_decode_word(w == 0, w == DEC_WORDS - 1);
        if (w < DEC_WORDS - 1 && rand_bits(1) == 1) drive_idle();  // hole in frame
      end
      repeat (3 + int'(rand_bits(2))) drive_idle();  // eop written before next sop
    end

    for (int i = 0; i < UP_WORDS; i++) drive_upload_word(i == 0);
    drive_idle();

    while (wr_q.size() > 0 || bit_q.size() > 0 || busy_q.size() > 0) begin
      @(negedge iclk);
    end
    repeat (2) @(negedge iclk);  // last expectations get checked

    $display("sim passed");
    $finish;
  end

endmodule

// File: hw/ldpc_vnode.sv
// ldpc variable-node stage top: four lane engines, write-back, error counter and control

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module ldpc_vnode (
  input  logic                        iclk,
  input  logic                        ireset,
  // decode word
  input  logic                        isop,
  input  logic                        ival,
  input  logic                        ieop,
  input  ldpc_vnode_pkg::llr_t        illr    [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE],
  input  ldpc_vnode_pkg::node_t       icnode  [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE],
  // check-node state, the plain sum does not look at it
  input  ldpc_vnode_pkg::node_state_t icstate [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE],
  // initial upload word
  input  logic                        iusop,
  input  logic                        iuval,
  input  ldpc_vnode_pkg::llr_t        iullr   [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE],
  // node memory write
  output logic                        oval,
  output ldpc_vnode_pkg::mem_addr_t   oaddr,
  output ldpc_vnode_pkg::node_t       ovnode  [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE],
  output ldpc_vnode_pkg::node_state_t ovstate [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE],
  // hard decisions
  output logic                        obitsop,
  output logic                        obitval,
  output logic                        obiteop,
  output logic [`LDPC_LLR_BY_CYCLE-1:0] obitdat [`LDPC_NODE_BY_CYCLE],
  output logic [`LDPC_ERR_W-1:0]      obiterr,
  output logic                        obusy
);

  logic                        wb_load;
  logic                        wb_upload;

  ldpc_vnode_pkg::node_t       lane_cnode [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE][`LDPC_C];
  ldpc_vnode_pkg::node_t       eng_vnode  [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE][`LDPC_C];
  ldpc_vnode_pkg::node_state_t eng_state  [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE][`LDPC_C];
  logic                        eng_bit    [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE];
  logic                        eng_err    [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE];

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  ldpc_vnode_ctrl ctrl_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .isop      (isop),
    .ival      (ival),
    .ieop      (ieop),
    .iusop     (iusop),
    .iuval     (iuval),
    .wb_load   (wb_load),
    .wb_upload (wb_upload),
    .oval      (oval),
    .oaddr     (oaddr),
    .obusy     (obusy),
    .obitsop   (obitsop),
    .obitval   (obitval),
    .obiteop   (obiteop)
  );

  // ----------------------------------------------------------
  // lane engines, messages regrouped lane major
  // ----------------------------------------------------------
  for (genvar l = 0; l < `LDPC_LLR_BY_CYCLE; l++) begin : g_llr
    for (genvar n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin : g_node
      for (genvar c = 0; c < `LDPC_C; c++) begin : g_edge
        assign lane_cnode[l][n][c] = icnode[c][l][n];
      end

      ldpc_vnode_engine engine_inst (
        .iclk    (iclk),
        .illr    (illr[l][n]),
        .icnode  (lane_cnode[l][n]),
        .ovnode  (eng_vnode[l][n]),
        .ovstate (eng_state[l][n]),
        .obit    (eng_bit[l][n]),
        .oerr    (eng_err[l][n])
      );
    end
  end

  // ----------------------------------------------------------
  // write data and bit-error sum
  // ----------------------------------------------------------
  ldpc_vnode_writeback writeback_inst (
    .iclk      (iclk),
    .wb_load   (wb_load),
    .wb_upload (wb_upload),
    .iullr     (iullr),
    .evnode    (eng_vnode),
    .evstate   (eng_state),
    .ovnode    (ovnode),
    .ovstate   (ovstate)
  );

  ldpc_vnode_err_count err_count_inst (
    .iclk    (iclk),
    .ebit    (eng_bit),
    .eerr    (eng_err),
    .obitdat (obitdat),
    .obiterr (obiterr)
  );

endmodule

// File: hw/ldpc_vnode_err_count.sv
// ldpc variable-node bit-error counter, two adder stages, hard bits carried alongside

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module ldpc_vnode_err_count (
  input  logic                           iclk,
  input  logic                           ebit    [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE],
  input  logic                           eerr    [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE],
  output logic [`LDPC_LLR_BY_CYCLE-1:0]  obitdat [`LDPC_NODE_BY_CYCLE],
  output logic [`LDPC_ERR_W-1:0]         obiterr
);

  localparam int L = `LDPC_LLR_BY_CYCLE;

  logic [`LDPC_LANES-1:0]       err_vec;                     // column n at [n*L +: L]
  logic [L-1:0]                 bit_col  [`LDPC_NODE_BY_CYCLE];
  logic [`LDPC_ERR_STAGE_W-1:0] part     [`LDPC_NODE_BY_CYCLE];  // stage 0
  logic [L-1:0]                 bit_s0   [`LDPC_NODE_BY_CYCLE];  // stage 0
  logic [`LDPC_ERR_W-1:0]       total_c;

  // ----------------------------------------------------------
  // regroup lanes by node column
  // ----------------------------------------------------------
  always_comb begin
    for (int n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin
      for (int l = 0; l < L; l++) begin
        err_vec[n*L + l] = eerr[l][n];
        bit_col[n][l]    = ebit[l][n];
      end
    end
  end

  // stage 0: one partial per column
  always_ff @(posedge iclk) begin
    for (int n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin
      part[n]   <= `LDPC_ERR_STAGE_W'($countones(err_vec[n*L +: L]));
      bit_s0[n] <= bit_col[n];
    end
  end

  // ----------------------------------------------------------
  // stage 1: partials to the frame-word count
  // ----------------------------------------------------------
  always_comb begin
    total_c = '0;
    for (int n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin
      total_c = total_c + `LDPC_ERR_W'(part[n]);  // zero extended
    end
  end

  always_ff @(posedge iclk) begin
    obiterr <= total_c;
    obitdat <= bit_s0;
  end

endmodule

// File: hw/ldpc_vnode_writeback.sv
// ldpc variable-node write data: upload llr or engine messages, registered per edge and lane

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module ldpc_vnode_writeback (
  input  logic                        iclk,
  input  logic                        wb_load,
  input  logic                        wb_upload,
  input  ldpc_vnode_pkg::llr_t        iullr   [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE],
  input  ldpc_vnode_pkg::node_t       evnode  [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE]
                                              [`LDPC_C],
  input  ldpc_vnode_pkg::node_state_t evstate [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE]
                                              [`LDPC_C],
  output ldpc_vnode_pkg::node_t       ovnode  [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE],
  output ldpc_vnode_pkg::node_state_t ovstate [`LDPC_C][`LDPC_LLR_BY_CYCLE]
                                              [`LDPC_NODE_BY_CYCLE]
);

  // uploaded word looks like a positive, zero-valued node state
  localparam ldpc_vnode_pkg::node_state_t UP_STATE = '{pre_sign: 1'b0, pre_zero: 1'b1};

  ldpc_vnode_pkg::node_t up_node [`LDPC_LLR_BY_CYCLE][`LDPC_NODE_BY_CYCLE];

  // ----------------------------------------------------------
  // upload llr scaled to node width
  // ----------------------------------------------------------
  always_comb begin
    for (int l = 0; l < `LDPC_LLR_BY_CYCLE; l++) begin
      for (int n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin
        up_node[l][n] = ldpc_vnode_pkg::node_t'(iullr[l][n]) <<< `LDPC_LLR_SHIFT;
      end
    end
  end

  // ----------------------------------------------------------
  // write data register, edge major on the way out
  // ----------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (wb_load) begin
      for (int c = 0; c < `LDPC_C; c++) begin
        for (int l = 0; l < `LDPC_LLR_BY_CYCLE; l++) begin
          for (int n = 0; n < `LDPC_NODE_BY_CYCLE; n++) begin
            if (wb_upload) begin
              ovnode[c][l][n]  <= up_node[l][n];  // same llr on every edge
              ovstate[c][l][n] <= UP_STATE;
            end else begin
              ovnode[c][l][n]  <= evnode[l][n][c];
              ovstate[c][l][n] <= evstate[l][n][c];
            end
          end
        end
      end
    end
  end

endmodule

// File: hw/ldpc_vnode_engine.sv
// ldpc variable-node lane: total, extrinsic messages, state, hard bit and bit error

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module ldpc_vnode_engine (
  input  logic                        iclk,
  input  ldpc_vnode_pkg::llr_t        illr,
  input  ldpc_vnode_pkg::node_t       icnode  [`LDPC_C],
  output ldpc_vnode_pkg::node_t       ovnode  [`LDPC_C],
  output ldpc_vnode_pkg::node_state_t ovstate [`LDPC_C],
  output logic                        obit,
  output logic                        oerr
);

  // llr plus LDPC_C messages never leaves this range
  localparam int ACC_W    = `LDPC_NODE_W + $clog2(`LDPC_C + 1);
  localparam int NODE_MAX = 2**(`LDPC_NODE_W - 1) - 1;
  localparam int NODE_MIN = -(2**(`LDPC_NODE_W - 1));

  typedef logic signed [ACC_W-1:0] acc_t;

  acc_t                  msg_sum_c;            // comb sum of incoming messages
  ldpc_vnode_pkg::node_t llr_ext;              // stage 1
  acc_t                  msg_sum;              // stage 1
  ldpc_vnode_pkg::node_t cnode_r [`LDPC_C];    // stage 1, kept for extrinsic
  acc_t                  total;
  acc_t                  ext     [`LDPC_C];
  ldpc_vnode_pkg::node_t ext_sat [`LDPC_C];

  function automatic ldpc_vnode_pkg::node_t sat (input acc_t a);
    if (a > acc_t'(NODE_MAX)) begin
      sat = ldpc_vnode_pkg::node_t'(NODE_MAX);
    end else if (a < acc_t'(NODE_MIN)) begin
      sat = ldpc_vnode_pkg::node_t'(NODE_MIN);
    end else begin
      sat = ldpc_vnode_pkg::node_t'(a);
    end
  endfunction

  // ----------------------------------------------------------
  // stage 1: llr to node scale, message sum
  // ----------------------------------------------------------
  always_comb begin
    msg_sum_c = '0;
    for (int c = 0; c < `LDPC_C; c++) begin
      msg_sum_c = msg_sum_c + acc_t'(icnode[c]);  // sign extended
    end
  end

  always_ff @(posedge iclk) begin
    llr_ext <= ldpc_vnode_pkg::node_t'(illr) <<< `LDPC_LLR_SHIFT;
    msg_sum <= msg_sum_c;
    cnode_r <= icnode;
  end

  // ----------------------------------------------------------
  // stage 2: extrinsic per edge
  // ----------------------------------------------------------
  assign total = acc_t'(llr_ext) + msg_sum;

  always_comb begin
    for (int c = 0; c < `LDPC_C; c++) begin
      ext[c]     = total - acc_t'(cnode_r[c]);  // leave own edge out
      ext_sat[c] = sat(ext[c]);
    end
  end

  always_ff @(posedge iclk) begin
    for (int c = 0; c < `LDPC_C; c++) begin
      ovnode[c]          <= ext_sat[c];
      ovstate[c].pre_sign <= ext_sat[c][`LDPC_NODE_W-1];
      ovstate[c].pre_zero <= (ext_sat[c] == '0);
    end
    obit <= total[ACC_W-1];                              // negative total -> 1
    oerr <= total[ACC_W-1] ^ llr_ext[`LDPC_NODE_W-1];    // flipped vs channel
  end

endmodule

// File: hw/ldpc_vnode_ctrl.sv
// ldpc variable-node control: strobe alignment, write address, frame phase and busy

`timescale 1ns/1ps

`include "ldpc_macros.svh"

module ldpc_vnode_ctrl (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      isop,
  input  logic                      ival,
  input  logic                      ieop,
  input  logic                      iusop,
  input  logic                      iuval,
  output logic                      wb_load,
  output logic                      wb_upload,
  output logic                      oval,
  output ldpc_vnode_pkg::mem_addr_t oaddr,
  output logic                      obusy,
  output logic                      obitsop,
  output logic                      obitval,
  output logic                      obiteop
);

  // bit 1 lines up with engine outputs, bit 3 with the error counter output
  logic [3:0] val_sr;
  logic [3:0] sop_sr;
  logic [3:0] eop_sr;

  logic       wr_sop;   // sop of the word being written now

  ldpc_vnode_pkg::frame_phase_t phase;

  // ----------------------------------------------------------
  // decode strobe pipeline
  // ----------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr <= '0;
      sop_sr <= '0;
      eop_sr <= '0;
    end else begin
      val_sr <= {val_sr[2:0], ival};
      sop_sr <= {sop_sr[2:0], isop};
      eop_sr <= {eop_sr[2:0], ieop};
    end
  end

  assign obitval = val_sr[3];
  assign obitsop = sop_sr[3];
  assign obiteop = eop_sr[3];

  // ----------------------------------------------------------
  // write port: upload has the port when iuval is high
  // ----------------------------------------------------------
  assign wb_upload = iuval;
  assign wb_load   = iuval | val_sr[1];
  assign wr_sop    = iuval ? iusop : sop_sr[1];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval  <= 1'b0;
      oaddr <= '0;
    end else begin
      oval <= wb_load;
      if (wb_load) begin
        oaddr <= wr_sop ? '0 : oaddr + 1'b1;  // restart on either sop
      end
    end
  end

  // ----------------------------------------------------------
  // frame phase
  // ----------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      phase <= ldpc_vnode_pkg::phase_idle;
    end else begin
      case (phase)
        ldpc_vnode_pkg::phase_idle,
        ldpc_vnode_pkg::phase_upload: begin
          if (ival && isop) begin
            phase <= ldpc_vnode_pkg::phase_decode;
          end else if (iuval && iusop) begin
            phase <= ldpc_vnode_pkg::phase_upload;
          end
        end
        ldpc_vnode_pkg::phase_decode: begin
          if (val_sr[2] && eop_sr[2]) begin  // eop word sits on oval now
            phase <= ldpc_vnode_pkg::phase_idle;
          end
        end
        default: phase <= ldpc_vnode_pkg::phase_idle;
      endcase
    end
  end

  assign obusy = (phase == ldpc_vnode_pkg::phase_decode);

  // upload word must not meet a decode word two cycles behind ival
  a_no_collision : assert property (@(posedge iclk) disable iff (ireset)
    !(iuval && val_sr[1]));

  // a new decode frame only once the previous eop is written
  a_no_sop_in_frame : assert property (@(posedge iclk) disable iff (ireset)
    (ival && isop) |-> (phase != ldpc_vnode_pkg::phase_decode));

endmodule

// File: hw/ldpc_vnode_pkg.sv
// ldpc variable-node types: llr, message, node state, address and frame phase

`include "ldpc_macros.svh"

package ldpc_vnode_pkg;

  // channel llr as delivered by the demapper
  typedef logic signed [`LDPC_LLR_W-1:0]  llr_t;

  // edge message, check-node side and variable-node side
  typedef logic signed [`LDPC_NODE_W-1:0] node_t;

  // per-edge state stored beside the message
  typedef struct packed {
    logic pre_sign;  // 1 = negative
    logic pre_zero;  // 1 = exactly zero
  } node_state_t;

  typedef logic [`LDPC_ADDR_W-1:0] mem_addr_t;

  // what the stage is doing right now
  typedef enum logic [1:0] {
    phase_idle   = 2'd0,
    phase_upload = 2'd1,  // initial llr load
    phase_decode = 2'd2   // decode frame in flight
  } frame_phase_t;

endpackage

// File: hw/ldpc_macros.svh
// ldpc variable-node stage widths, lane grid and column weight

`ifndef LDPC_MACROS_SVH
`define LDPC_MACROS_SVH

// ----------------------------------------------------------
// data widths
// ----------------------------------------------------------
`define LDPC_LLR_W          4   // channel llr, signed
`define LDPC_NODE_W         6   // check/variable node message, signed

// llr is placed at the top of the node word
`define LDPC_LLR_SHIFT      (`LDPC_NODE_W - `LDPC_LLR_W)

// ----------------------------------------------------------
// lane grid
// ----------------------------------------------------------
`define LDPC_C              2   // edges per variable node
`define LDPC_LLR_BY_CYCLE   2
`define LDPC_NODE_BY_CYCLE  2
`define LDPC_LANES          (`LDPC_LLR_BY_CYCLE * `LDPC_NODE_BY_CYCLE)

// ----------------------------------------------------------
// address and bit-error counter
// ----------------------------------------------------------
`define LDPC_ADDR_W         8
`define LDPC_ERR_W          3   // holds 0..LDPC_LANES
`define LDPC_ERR_STAGE_W    2   // one node column partial

`endif
